//--- Makefile
VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert
TOP = cacheSequencerTb
FILELIST = sim.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/cacheSequencerTb.sv
`timescale 1ns/1ns

module cacheSequencerTb;

  localparam int NumWays = 4;
  localparam int LruBits = $clog2(NumWays);
  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 10;
  localparam int KindMb = 0;
  localparam int KindChan = 1;
  localparam int KindEbox = 2;
  localparam int KindCca = 3;
  localparam int NumPrio = 40;
  localparam int NumReadHit = 20;
  localparam int NumReadMiss = 20;
  localparam int NumWrite = 30;
  localparam int NumOther = 30;
  localparam int TotalTrans = NumPrio + NumReadHit + NumReadMiss + NumWrite + NumOther;
  // 40 cycles per transaction bounds even the longest read miss
  localparam int WatchdogNs = (TotalTrans * 40 + ResetCycles + 20) * ClkPeriod;

  logic clk = 1'b0;
  logic reset;
  logic mbReq;
  logic chanReq;
  logic eboxReq;
  logic ccaReq;
  logic eboxRead;
  logic cacheBit;
  logic [NumWays-1:0] wayValidMatch;
  logic [NumWays-1:0] wayWritten;
  logic [NumWays-1:0] wayWordValid;
  logic [LruBits-1:0] lruSel;
  logic coreDataValid;
  logic mbGrant;
  logic chanGrant;
  logic eboxGrant;
  logic ccaGrant;
  logic cacheIdle;
  logic mbCyc;
  logic chanCyc;
  logic eboxCyc;
  logic ccaCyc;
  logic mboxResp;
  logic cacheWrite;
  logic writebackStart;
  logic coreReadReq;

  logic [31:0] lfsrState = 32'h744270f1;
  int checkTotal = 0;
  int errorCount = 0;

  always #(ClkPeriod / 2) clk = ~clk;

  cacheSequencer #(
    .NumWays (NumWays)
  ) u_dut (
    .clk            (clk),
    .reset          (reset),
    .mbReq          (mbReq),
    .chanReq        (chanReq),
    .eboxReq        (eboxReq),
    .ccaReq         (ccaReq),
    .eboxRead       (eboxRead),
    .cacheBit       (cacheBit),
    .wayValidMatch  (wayValidMatch),
    .wayWritten     (wayWritten),
    .wayWordValid   (wayWordValid),
    .lruSel         (lruSel),
    .coreDataValid  (coreDataValid),
    .mbGrant        (mbGrant),
    .chanGrant      (chanGrant),
    .eboxGrant      (eboxGrant),
    .ccaGrant       (ccaGrant),
    .cacheIdle      (cacheIdle),
    .mbCyc          (mbCyc),
    .chanCyc        (chanCyc),
    .eboxCyc        (eboxCyc),
    .ccaCyc         (ccaCyc),
    .mboxResp       (mboxResp),
    .cacheWrite     (cacheWrite),
    .writebackStart (writebackStart),
    .coreReadReq    (coreReadReq)
  );

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  task automatic checkSignal(input string name, input logic expected, input logic actual);
    checkTotal++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %0b got %0b", $time, name, expected, actual);
    end
  endtask

  task automatic checkLevels(input int kind, input logic busy);
    checkSignal("cacheIdle", ~busy, cacheIdle);
    checkSignal("mbCyc", busy && kind == KindMb, mbCyc);
    checkSignal("chanCyc", busy && kind == KindChan, chanCyc);
    checkSignal("eboxCyc", busy && kind == KindEbox, eboxCyc);
    checkSignal("ccaCyc", busy && kind == KindCca, ccaCyc);
  endtask

  // Highest priority request wins
  function automatic int winnerOf(input logic [3:0] reqMask);
    if (reqMask[0]) return KindMb;
    else if (reqMask[1]) return KindChan;
    else if (reqMask[2]) return KindEbox;
    else return KindCca;
  endfunction

  task automatic predictOutcome(
    input int kind, input logic read, input logic cache,
    input logic [NumWays-1:0] validMatch, input logic [NumWays-1:0] written,
    input logic [NumWays-1:0] wordValid, input logic [LruBits-1:0] lru,
    output logic resp, output logic write, output logic wb, output logic miss
  );
    logic anyV;
    logic found;
    logic dirtyMatch;
    logic victim;
    anyV = 1'b0;
    found = 1'b0;
    dirtyMatch = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (validMatch[w]) begin
        anyV = 1'b1;
        if (wordValid[w]) found = 1'b1;
        if (written[w]) dirtyMatch = 1'b1;
      end
    end
    victim = written[lru];
    resp = 1'b0;
    write = 1'b0;
    wb = 1'b0;
    miss = 1'b0;
    if (kind == KindMb) begin
      write = 1'b1;
    end else if (kind != KindEbox) begin
      wb = anyV & dirtyMatch;
    end else if (read) begin
      resp = found;
      miss = ~found;
      wb = ~found & cache & ~anyV & victim;
    end else begin
      resp = 1'b1;
      write = anyV | cache;
      wb = ~anyV & cache & victim;
    end
  endtask

  task automatic runCycle(
    input logic [3:0] reqMask, input logic read, input logic cache,
    input logic [NumWays-1:0] validMatch, input logic [NumWays-1:0] written,
    input logic [NumWays-1:0] wordValid, input logic [LruBits-1:0] lru
  );
    int kind;
    int spins;
    logic expResp;
    logic expWrite;
    logic expWb;
    logic expMiss;
    logic [31:0] r;
    logic [3:0] delay;
    kind = winnerOf(reqMask);
    predictOutcome(kind, read, cache, validMatch, written, wordValid, lru,
                   expResp, expWrite, expWb, expMiss);
    @(posedge clk);
    mbReq <= reqMask[0];
    chanReq <= reqMask[1];
    eboxReq <= reqMask[2];
    ccaReq <= reqMask[3];
    eboxRead <= read;
    cacheBit <= cache;
    wayValidMatch <= validMatch;
    wayWritten <= written;
    wayWordValid <= wordValid;
    lruSel <= lru;
    @(negedge clk);
    checkSignal("mbGrant", kind == KindMb, mbGrant);
    checkSignal("chanGrant", kind == KindChan, chanGrant);
    checkSignal("eboxGrant", kind == KindEbox, eboxGrant);
    checkSignal("ccaGrant", kind == KindCca, ccaGrant);
    checkSignal("cacheIdle", 1'b1, cacheIdle);
    // Outcome strobes only in T3
    for (int k = 1; k <= 4; k++) begin
      @(posedge clk);
      if (k == 1) begin
        mbReq <= 1'b0;
        chanReq <= 1'b0;
        eboxReq <= 1'b0;
        ccaReq <= 1'b0;
      end
      @(negedge clk);
      checkLevels(kind, 1'b1);
      checkSignal("mboxResp", (k == 4) & expResp, mboxResp);
      checkSignal("cacheWrite", (k == 4) & expWrite, cacheWrite);
      checkSignal("writebackStart", (k == 4) & expWb, writebackStart);
      checkSignal("coreReadReq", 1'b0, coreReadReq);
    end
    if (expMiss) begin
      r = randBits(4);
      delay = r[3:0];
      repeat (int'(delay) + 1) begin
        @(posedge clk);
        @(negedge clk);
        checkSignal("coreReadReq", 1'b1, coreReadReq);
        checkSignal("mboxResp", 1'b0, mboxResp);
        checkLevels(kind, 1'b1);
      end
      @(posedge clk);
      coreDataValid <= 1'b1;
      @(negedge clk);
      checkSignal("coreReadReq", 1'b1, coreReadReq);
      @(posedge clk);
      coreDataValid <= 1'b0;
      @(negedge clk);
      spins = 1;
      while (mboxResp !== 1'b1 && spins < 8) begin
        @(posedge clk);
        @(negedge clk);
        spins++;
      end
      checkTotal++;
      if (mboxResp !== 1'b1) begin
        errorCount++;
        $display("Read miss got no response within 8 cycles of core data valid");
      end else begin
        if (spins != 1) begin
          errorCount++;
          $display("** Error at %0t ns: fillLatency expected 1 got %0d", $time, spins);
        end
        checkSignal("cacheWrite", cache, cacheWrite);
        checkSignal("writebackStart", 1'b0, writebackStart);
        checkSignal("coreReadReq", 1'b0, coreReadReq);
      end
    end
    @(posedge clk);
    @(negedge clk);
    checkLevels(kind, 1'b0);
    checkSignal("mboxResp", 1'b0, mboxResp);
    checkSignal("coreReadReq", 1'b0, coreReadReq);
  endtask

  task automatic finishTest(input string name, input int count, input int errsBefore);
    $display("%s: %0d transactions, %0d errors", name, count, errorCount - errsBefore);
  endtask

  task automatic resetState();
    int errsBefore;
    errsBefore = errorCount;
    repeat (3) begin
      @(negedge clk);
      checkLevels(KindMb, 1'b0);
      checkSignal("mbGrant", 1'b0, mbGrant);
      checkSignal("chanGrant", 1'b0, chanGrant);
      checkSignal("eboxGrant", 1'b0, eboxGrant);
      checkSignal("ccaGrant", 1'b0, ccaGrant);
      checkSignal("mboxResp", 1'b0, mboxResp);
      checkSignal("cacheWrite", 1'b0, cacheWrite);
      checkSignal("writebackStart", 1'b0, writebackStart);
      checkSignal("coreReadReq", 1'b0, coreReadReq);
    end
    finishTest("reset state", 0, errsBefore);
  endtask

  task automatic trafficMix(input string name, input int count, input int mode);
    int errsBefore;
    logic [31:0] r;
    logic [3:0] mask;
    logic read;
    logic cache;
    logic [NumWays-1:0] vm;
    logic [NumWays-1:0] ww;
    logic [NumWays-1:0] wv;
    logic [LruBits-1:0] lru;
    logic [LruBits-1:0] way;
    errsBefore = errorCount;
    for (int n = 0; n < count; n++) begin
      r = randBits(4);
      mask = r[3:0];
      r = randBits(1);
      read = r[0];
      r = randBits(1);
      cache = r[0];
      r = randBits(NumWays);
      vm = r[NumWays-1:0];
      r = randBits(NumWays);
      ww = r[NumWays-1:0];
      r = randBits(NumWays);
      wv = r[NumWays-1:0];
      r = randBits(LruBits);
      lru = r[LruBits-1:0];
      r = randBits(LruBits);
      way = r[LruBits-1:0];
      case (mode)
        0: if (mask == 4'b0000) mask = 4'b1000;
        1: begin
          mask = 4'b0100;
          read = 1'b1;
          vm[way] = 1'b1;
          wv[way] = 1'b1;
        end
        2: begin
          mask = 4'b0100;
          read = 1'b1;
          wv = wv & ~vm;
          // Half the misses find no valid line at all
          r = randBits(1);
          if (r[0]) begin
            vm = '0;
          end
        end
        3: begin
          mask = 4'b0100;
          read = 1'b0;
          // Pick a hit or one of the two miss kinds
          r = randBits(2);
          if (r[1:0] == 2'd1) begin
            vm = '0;
            cache = 1'b1;
          end else if (r[1:0] == 2'd2) begin
            vm = '0;
            cache = 1'b0;
          end else begin
            vm[way] = 1'b1;
          end
        end
        default: begin
          mask[2] = 1'b0;
          if (mask == 4'b0000) mask = 4'b0010;
        end
      endcase
      runCycle(mask, read, cache, vm, ww, wv, lru);
    end
    finishTest(name, count, errsBefore);
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all transactions completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int assertFails;
    reset = 1'b1;
    mbReq = 1'b0;
    chanReq = 1'b0;
    eboxReq = 1'b0;
    ccaReq = 1'b0;
    eboxRead = 1'b0;
    cacheBit = 1'b0;
    wayValidMatch = '0;
    wayWritten = '0;
    wayWordValid = '0;
    lruSel = '0;
    coreDataValid = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    resetState();
    trafficMix("priority", NumPrio, 0);
    trafficMix("read hit", NumReadHit, 1);
    trafficMix("read miss", NumReadMiss, 2);
    trafficMix("writes", NumWrite, 3);
    trafficMix("mb chan cca", NumOther, 4);
    assertFails = u_dut.u_props.failCount;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checkTotal, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/cacheSequencer_properties.sv
`timescale 1ns/1ns

module cacheSequencer_properties (
  input logic clk,
  input logic reset,
  input logic mbGrant,
  input logic chanGrant,
  input logic eboxGrant,
  input logic ccaGrant,
  input logic cacheIdle,
  input logic mbCyc,
  input logic chanCyc,
  input logic eboxCyc,
  input logic ccaCyc,
  input logic mboxResp,
  input logic coreReadReq
);

  int failCount = 0;

  grantOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({mbGrant, chanGrant, eboxGrant, ccaGrant}))
    else begin
      failCount++;
      $error("more than one grant high");
    end

  // Only one cycle in flight
  grantWhileBusy: assert property (@(posedge clk) disable iff (reset)
    !cacheIdle |-> !(mbGrant | chanGrant | eboxGrant | ccaGrant))
    else begin
      failCount++;
      $error("grant issued while cache busy");
    end

  respOnlyEbox: assert property (@(posedge clk) disable iff (reset)
    (mboxResp | coreReadReq) |-> eboxCyc)
    else begin
      failCount++;
      $error("processor response outside a processor cycle");
    end

  idleExcludesCycles: assert property (@(posedge clk) disable iff (reset)
    cacheIdle |-> !(mbCyc | chanCyc | eboxCyc | ccaCyc))
    else begin
      failCount++;
      $error("cycle level high while idle");
    end

endmodule

bind cacheSequencer cacheSequencer_properties u_props (
  .clk         (clk),
  .reset       (reset),
  .mbGrant     (mbGrant),
  .chanGrant   (chanGrant),
  .eboxGrant   (eboxGrant),
  .ccaGrant    (ccaGrant),
  .cacheIdle   (cacheIdle),
  .mbCyc       (mbCyc),
  .chanCyc     (chanCyc),
  .eboxCyc     (eboxCyc),
  .ccaCyc      (ccaCyc),
  .mboxResp    (mboxResp),
  .coreReadReq (coreReadReq)
);

//--- common/cachePkg.sv
package cachePkg;

  // Cycle type vector bit positions
  localparam int CycCca = 0;
  localparam int CycChan = 1;
  localparam int CycMb = 2;
  localparam int CycEbox = 3;

  // One bit per requester
  localparam int NumCycTypes = 4;

  // Cache associativity unless the top level overrides it
  localparam int DefaultNumWays = 4;

endpackage

//--- logic/cacheSequencer.sv
`timescale 1ns/1ns

module cacheSequencer #(
  parameter int NumWays = cachePkg::DefaultNumWays
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mbReq,
  input  logic                         chanReq,
  input  logic                         eboxReq,
  input  logic                         ccaReq,
  input  logic                         eboxRead,
  input  logic                         cacheBit,
  input  logic [NumWays-1:0]           wayValidMatch,
  input  logic [NumWays-1:0]           wayWritten,
  input  logic [NumWays-1:0]           wayWordValid,
  input  logic [$clog2(NumWays)-1:0]   lruSel,
  input  logic                         coreDataValid,
  output logic                         mbGrant,
  output logic                         chanGrant,
  output logic                         eboxGrant,
  output logic                         ccaGrant,
  output logic                         cacheIdle,
  output logic                         mbCyc,
  output logic                         chanCyc,
  output logic                         eboxCyc,
  output logic                         ccaCyc,
  output logic                         mboxResp,
  output logic                         cacheWrite,
  output logic                         writebackStart,
  output logic                         coreReadReq
);
  import cachePkg::*;

  logic [NumCycTypes-1:0] cycleType;
  logic readCycle;
  logic t2;
  logic t3;
  logic cycleDone;
  logic anyValidMatch;
  logic readFound;
  logic writtenMatch;
  logic victimWritten;

  assign mbCyc = cycleType[CycMb];
  assign chanCyc = cycleType[CycChan];
  assign eboxCyc = cycleType[CycEbox];
  assign ccaCyc = cycleType[CycCca];

  cycleArbiter u_cycleArbiter (
    .clk       (clk),
    .reset     (reset),
    .mbReq     (mbReq),
    .chanReq   (chanReq),
    .eboxReq   (eboxReq),
    .ccaReq    (ccaReq),
    .eboxRead  (eboxRead),
    .cycleDone (cycleDone),
    .mbGrant   (mbGrant),
    .chanGrant (chanGrant),
    .eboxGrant (eboxGrant),
    .ccaGrant  (ccaGrant),
    .cycleType (cycleType),
    .readCycle (readCycle),
    .cacheIdle (cacheIdle),
    .t2        (t2),
    .t3        (t3)
  );

  wayMatch #(
    .NumWays (NumWays)
  ) u_wayMatch (
    .clk           (clk),
    .reset         (reset),
    .t2            (t2),
    .wayValidMatch (wayValidMatch),
    .wayWritten    (wayWritten),
    .wayWordValid  (wayWordValid),
    .lruSel        (lruSel),
    .anyValidMatch (anyValidMatch),
    .readFound     (readFound),
    .writtenMatch  (writtenMatch),
    .victimWritten (victimWritten)
  );

  cycleResolver u_cycleResolver (
    .clk            (clk),
    .reset          (reset),
    .t2             (t2),
    .t3             (t3),
    .cycleType      (cycleType),
    .readCycle      (readCycle),
    .cacheBit       (cacheBit),
    .anyValidMatch  (anyValidMatch),
    .readFound      (readFound),
    .writtenMatch   (writtenMatch),
    .victimWritten  (victimWritten),
    .coreDataValid  (coreDataValid),
    .mboxResp       (mboxResp),
    .cacheWrite     (cacheWrite),
    .writebackStart (writebackStart),
    .coreReadReq    (coreReadReq),
    .cycleDone      (cycleDone)
  );

endmodule

//--- logic/cycleArbiter.sv
`timescale 1ns/1ns

module cycleArbiter (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mbReq,
  input  logic                               chanReq,
  input  logic                               eboxReq,
  input  logic                               ccaReq,
  input  logic                               eboxRead,
  input  logic                               cycleDone,
  output logic                               mbGrant,
  output logic                               chanGrant,
  output logic                               eboxGrant,
  output logic                               ccaGrant,
  output logic [cachePkg::NumCycTypes-1:0]   cycleType,
  output logic                               readCycle,
  output logic                               cacheIdle,
  output logic                               t2,
  output logic                               t3
);
  import cachePkg::*;

  logic [NumCycTypes-1:0] grantVec;
  logic anyGrant;
  logic t0;
  logic t1;

  // Idle whenever no cycle type is held
  assign cacheIdle = ~|cycleType;

  // Fixed priority from memory buffer down to sweep
  always_comb begin
    mbGrant = cacheIdle & mbReq;
    chanGrant = cacheIdle & ~mbReq & chanReq;
    eboxGrant = cacheIdle & ~mbReq & ~chanReq & eboxReq;
    ccaGrant = cacheIdle & ~mbReq & ~chanReq & ~eboxReq & ccaReq;
  end

  always_comb begin
    grantVec = '0;
    grantVec[CycMb] = mbGrant;
    grantVec[CycChan] = chanGrant;
    grantVec[CycEbox] = eboxGrant;
    grantVec[CycCca] = ccaGrant;
  end

  assign anyGrant = |grantVec;

  // Cycle type held from grant until the done pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleType <= '0;
      readCycle <= 1'b0;
    end else if (anyGrant) begin
      cycleType <= grantVec;
      readCycle <= eboxGrant & eboxRead;
    end else if (cycleDone) begin
      cycleType <= '0;
      readCycle <= 1'b0;
    end
  end

  // One start bit per grant walks the T0..T3 chain
  always_ff @(posedge clk) begin
    if (reset) begin
      t0 <= 1'b0;
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
    end else begin
      t0 <= anyGrant;
      t1 <= t0;
      t2 <= t1;
      t3 <= t2;
    end
  end

endmodule

//--- logic/cycleResolver.sv
`timescale 1ns/1ns

module cycleResolver (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               t2,
  input  logic                               t3,
  input  logic [cachePkg::NumCycTypes-1:0]   cycleType,
  input  logic                               readCycle,
  input  logic                               cacheBit,
  input  logic                               anyValidMatch,
  input  logic                               readFound,
  input  logic                               writtenMatch,
  input  logic                               victimWritten,
  input  logic                               coreDataValid,
  output logic                               mboxResp,
  output logic                               cacheWrite,
  output logic                               writebackStart,
  output logic                               coreReadReq,
  output logic                               cycleDone
);
  import cachePkg::*;

  logic cacheBitHeld;
  logic mbCyc;
  logic eboxCyc;
  logic sweepCyc;
  logic readHitT3;
  logic readMissT3;
  logic writeT3;
  logic victimDirty;
  logic coreReadDone;
  logic fillDone;

  always_comb begin
    mbCyc = cycleType[CycMb];
    eboxCyc = cycleType[CycEbox];
    // Channel and sweep both only look for dirty lines
    sweepCyc = cycleType[CycChan] | cycleType[CycCca];
  end

  always_comb begin
    readHitT3 = t3 & eboxCyc & readCycle & readFound;
    readMissT3 = t3 & eboxCyc & readCycle & ~readFound;
    writeT3 = t3 & eboxCyc & ~readCycle;
    // Allocation on a miss evicts the LRU way
    victimDirty = cacheBitHeld & ~anyValidMatch & victimWritten;
    coreReadDone = coreReadReq & coreDataValid;
  end

  always_ff @(posedge clk) begin
    if (t2) begin
      cacheBitHeld <= cacheBit;
    end
  end

  // Core read wait ends on core data valid
  always_ff @(posedge clk) begin
    if (reset) begin
      coreReadReq <= 1'b0;
      fillDone <= 1'b0;
    end else begin
      coreReadReq <= readMissT3 | (coreReadReq & ~coreDataValid);
      fillDone <= coreReadDone;
    end
  end

  always_comb begin
    mboxResp = readHitT3 | writeT3 | fillDone;

    cacheWrite = (t3 & mbCyc) |
                 (writeT3 & (anyValidMatch | cacheBitHeld)) |
                 (fillDone & cacheBitHeld);

    writebackStart = (t3 & sweepCyc & anyValidMatch & writtenMatch) |
                     (readMissT3 & victimDirty) |
                     (writeT3 & victimDirty);

    // A read miss finishes only after the core data arrives
    cycleDone = (t3 & ~readMissT3) | fillDone;
  end

endmodule

//--- logic/wayMatch.sv
`timescale 1ns/1ns

module wayMatch #(
  parameter int NumWays = cachePkg::DefaultNumWays
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         t2,
  input  logic [NumWays-1:0]           wayValidMatch,
  input  logic [NumWays-1:0]           wayWritten,
  input  logic [NumWays-1:0]           wayWordValid,
  input  logic [$clog2(NumWays)-1:0]   lruSel,
  output logic                         anyValidMatch,
  output logic                         readFound,
  output logic                         writtenMatch,
  output logic                         victimWritten
);

  logic anyValidMatchIn;
  logic readFoundIn;
  logic writtenMatchIn;
  logic victimWrittenIn;

  always_comb begin
    anyValidMatchIn = |wayValidMatch;
    // Hit needs the word itself valid in the matching way
    readFoundIn = |(wayValidMatch & wayWordValid);
    writtenMatchIn = |(wayValidMatch & wayWritten);
    victimWrittenIn = wayWritten[lruSel];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      anyValidMatch <= 1'b0;
      readFound <= 1'b0;
      writtenMatch <= 1'b0;
      victimWritten <= 1'b0;
    end else if (t2) begin
      anyValidMatch <= anyValidMatchIn;
      readFound <= readFoundIn;
      writtenMatch <= writtenMatchIn;
      victimWritten <= victimWrittenIn;
    end
  end

endmodule

//--- sim.f
common/cachePkg.sv
logic/cycleArbiter.sv
logic/wayMatch.sv
logic/cycleResolver.sv
logic/cacheSequencer.sv
bench/cacheSequencer_properties.sv
bench/cacheSequencerTb.sv
